/* zx_pager.f */
zx_pager_pkg.sv
bus_decode.sv
paging_regs.sv
address_map.sv
zx_pager.sv
tb_zx_pager_properties.sv
tb_zx_pager.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_zx_pager
FILELIST  ?= zx_pager.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator, log in $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_zx_pager.sv */
//==========================================================
// Testbench for the paging unit
// Clock, reset, LFSR stimulus, reference model, RAM stalls,
// watchdog and test reporting
//==========================================================

`timescale 1ns/1ps

module tb_zx_pager
	import zx_pager_pkg::*;
;

	localparam logic [RAM_ADDR_W-1:0] TB_RAM_BASE = 25'h0200000;
	localparam logic [15:0] LFSR_SEED  = 16'd36439;
	localparam int          EXP_W      = RAM_ADDR_W + 10;
	localparam int          BP_CYCLES  = 300;
	localparam int          ULA_WRITES = 8;
	// Upper bound of bus cycles over all tests at 50 clocks each
	localparam int ISSUE_BUDGET    = 240 + BP_CYCLES + 2 * ULA_WRITES;
	localparam int WATCHDOG_CYCLES = 50 * ISSUE_BUDGET;

	logic                  clk_sys;
	logic                  reset;
	machine_model_t        model;
	logic                  bus_valid;
	cycle_kind_t           bus_kind;
	logic [CPU_ADDR_W-1:0] bus_addr;
	logic [7:0]            bus_data;
	logic                  bus_ready;
	logic                  ram_valid;
	logic [RAM_ADDR_W-1:0] ram_addr;
	logic                  ram_we;
	logic                  ram_rd;
	logic [7:0]            ram_din;
	logic                  ram_ready = 1'b1;
	logic [2:0]            border;
	logic                  ear;
	logic                  mic;

	// Reference state and expected RAM requests
	machine_model_t        ref_model;
	logic [7:0]            ref_p7;
	logic [7:0]            ref_p3;
	logic [4:0]            ref_ula;
	logic [EXP_W-1:0]      exp_q[$];
	logic [EXP_W-1:0]      exp_head = '0;
	logic                  exp_avail = 1'b0;

	logic [15:0] stim_lfsr  = LFSR_SEED;
	logic [15:0] stall_lfsr = LFSR_SEED;
	bit          stall_en   = 1'b0;
	string       test_name  = "none";
	int          check_fails  = 0;
	int          start_fails  = 0;
	int          tests_run    = 0;
	int          tests_failed = 0;

	zx_pager #(
		.RAM_BASE (TB_RAM_BASE)
	) dut (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.model     (model),
		.bus_valid (bus_valid),
		.bus_kind  (bus_kind),
		.bus_addr  (bus_addr),
		.bus_data  (bus_data),
		.bus_ready (bus_ready),
		.ram_valid (ram_valid),
		.ram_addr  (ram_addr),
		.ram_we    (ram_we),
		.ram_rd    (ram_rd),
		.ram_din   (ram_din),
		.ram_ready (ram_ready),
		.border    (border),
		.ear       (ear),
		.mic       (mic)
	);

	bind zx_pager tb_zx_pager_properties u_props (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	//==========================================================
	// Random numbers
	//==========================================================

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [31:0] rnd(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], stim_lfsr[0]};
			stim_lfsr = lfsr_next(stim_lfsr);
		end
		return v;
	endfunction

	// Random RAM stalls from one LFSR bit per cycle
	always @(posedge clk_sys) begin
		if (stall_en) begin
			stall_lfsr = lfsr_next(stall_lfsr);
			ram_ready <= stall_lfsr[0];
		end else
			ram_ready <= 1'b1;
	end

	//==========================================================
	// Reference model of the paging rules
	//==========================================================

	function automatic logic [RAM_ADDR_W-1:0] ref_ram_addr(input logic [15:0] a);
		logic [11:0] tab;
		logic [3:0]  rom;
		logic [7:0]  region;
		if (ref_p3[0]) begin
			// Banks of slots 3..0 for each all-RAM mode
			case (ref_p3[2:1])
				2'd0:    tab = {3'd3, 3'd2, 3'd1, 3'd0};
				2'd1:    tab = {3'd7, 3'd6, 3'd5, 3'd4};
				2'd2:    tab = {3'd3, 3'd6, 3'd5, 3'd4};
				default: tab = {3'd3, 3'd6, 3'd7, 3'd4};
			endcase
			case (a[15:14])
				2'd0:    region = {5'd0, tab[2:0]};
				2'd1:    region = {5'd0, tab[5:3]};
				2'd2:    region = {5'd0, tab[8:6]};
				default: region = {5'd0, tab[11:9]};
			endcase
		end else begin
			case (a[15:14])
				2'd0: begin
					if (ref_model == model_plus3)
						rom = {2'b10, ref_p3[2], ref_p7[4]};
					else if (ref_model == model_128)
						rom = {3'b011, ref_p7[4]};
					else
						rom = 4'b0111;
					region = {ROM_REGION, rom};
				end
				2'd1:    region = 8'd5;
				2'd2:    region = 8'd2;
				default: region = {5'd0, ref_p7[2:0]};
			endcase
		end
		return TB_RAM_BASE + {3'd0, region, a[13:0]};
	endfunction

	function automatic void ref_io_write(input logic [15:0] a, input logic [7:0] d);
		logic lock;
		lock = ref_p7[5];
		if (!a[15] && !a[1] && ref_model != model_48 && !lock &&
			(ref_model != model_plus3 || a[14]))
			ref_p7 = d;
		if (!a[1] && a[12] && a[15:13] == 3'b000 && ref_model == model_plus3 && !lock)
			ref_p3 = d;
		if (!a[0])
			ref_ula = {d[2:0], d[4], d[3]};
	endfunction

	// Follows accepted bus cycles and retired RAM requests
	always @(posedge clk_sys) begin : ref_monitor
		if (reset) begin
			ref_model = model;
			ref_p7    = '0;
			ref_p3    = '0;
			ref_ula   = '0;
			exp_q.delete();
		end else begin
			if (ram_valid && ram_ready && exp_q.size() != 0)
				void'(exp_q.pop_front());
			if (bus_valid && bus_ready) begin
				if (bus_kind == cyc_io_wr)
					ref_io_write(bus_addr, bus_data);
				else if (bus_kind == cyc_mem_rd)
					exp_q.push_back({1'b0, 1'b1, bus_data, ref_ram_addr(bus_addr)});
				else if (ref_p3[0] || bus_addr[15:14] != 2'd0)
					exp_q.push_back({1'b1, 1'b0, bus_data, ref_ram_addr(bus_addr)});
			end
		end
		exp_avail <= (exp_q.size() != 0);
		exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
	end

	//==========================================================
	// Bus driver and test helpers
	//==========================================================

	task automatic issue(input cycle_kind_t kind, input logic [15:0] addr,
		input logic [7:0] data);
		bus_valid <= 1'b1;
		bus_kind  <= kind;
		bus_addr  <= addr;
		bus_data  <= data;
		@(posedge clk_sys);
		while (!bus_ready)
			@(posedge clk_sys);
	endtask

	task automatic access(input cycle_kind_t kind, input logic [1:0] slot);
		logic [13:0] off;
		logic [7:0]  d;
		off = 14'(rnd(14));
		d   = 8'(rnd(8));
		issue(kind, {slot, off}, d);
	endtask

	task automatic idle();
		bus_valid <= 1'b0;
		@(posedge clk_sys);
	endtask

	// Waits for an empty pipeline and checks that no expected request is left
	task automatic drain();
		bus_valid <= 1'b0;
		do
			@(posedge clk_sys);
		while (dut.u_bus_decode.s1_valid || dut.u_paging_regs.item_valid || ram_valid);
		assert (exp_q.size() == 0) else begin
			$display("Test %s lost %0d expected RAM requests", test_name, exp_q.size());
			check_fails++;
		end
	endtask

	task automatic do_reset(input machine_model_t m);
		drain();
		model <= m;
		reset <= 1'b1;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic check_ula();
		assert ({border, ear, mic} == ref_ula) else begin
			$display("MISMATCH %s expected %h actual %h", test_name, ref_ula,
				{border, ear, mic});
			check_fails++;
		end
	endtask

	function automatic int total_fails();
		return check_fails + dut.u_props.assert_fails;
	endfunction

	task automatic start_test(input string name);
		test_name   = name;
		start_fails = total_fails();
	endtask

	task automatic finish_test();
		int errs;
		drain();
		errs = total_fails() - start_fails;
		tests_run++;
		if (errs == 0)
			$display("test %s: ok", test_name);
		else begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", test_name, errs);
		end
	endtask

	//==========================================================
	// Tests
	//==========================================================

	task automatic test_paging_128k();
		start_test("paging_128k");
		do_reset(model_128);
		for (int b = 0; b < 8; b++) begin
			for (int r = 0; r < 2; r++) begin
				issue(cyc_io_wr, 16'h7FFD, {3'b000, r[0], rnd(1) != 0, b[2:0]});
				for (int s = 0; s < 4; s++)
					access(cyc_mem_rd, s[1:0]);
				for (int s = 1; s < 4; s++)
					access(cyc_mem_wr, s[1:0]);
			end
		end
		finish_test();
	endtask

	task automatic test_lock_and_model();
		start_test("lock_and_model");
		do_reset(model_128);
		issue(cyc_io_wr, 16'h7FFD, 8'h23);
		access(cyc_mem_rd, 2'd3);
		// Locked so bank 6 and ROM 1 stay out
		issue(cyc_io_wr, 16'h7FFD, 8'h16);
		access(cyc_mem_rd, 2'd3);
		access(cyc_mem_rd, 2'd0);
		do_reset(model_plus3);
		issue(cyc_io_wr, 16'h7FFD, 8'h21);
		issue(cyc_io_wr, 16'h1FFD, 8'h01);
		access(cyc_mem_rd, 2'd0);
		access(cyc_mem_wr, 2'd0);
		access(cyc_mem_rd, 2'd3);
		do_reset(model_48);
		issue(cyc_io_wr, 16'h7FFD, 8'h17);
		access(cyc_mem_rd, 2'd0);
		access(cyc_mem_rd, 2'd3);
		finish_test();
	endtask

	task automatic test_plus3_special();
		start_test("plus3_special");
		do_reset(model_plus3);
		for (int c = 0; c < 4; c++) begin
			issue(cyc_io_wr, 16'h1FFD, {5'd0, c[1:0], 1'b1});
			for (int s = 0; s < 4; s++) begin
				access(cyc_mem_rd, s[1:0]);
				access(cyc_mem_wr, s[1:0]);
			end
		end
		// ROM page from 1FFD bit 2 and rom_lo
		for (int h = 0; h < 2; h++) begin
			for (int r = 0; r < 2; r++) begin
				issue(cyc_io_wr, 16'h1FFD, {5'd0, h[0], 2'b00});
				issue(cyc_io_wr, 16'h7FFD, {3'b000, r[0], 4'd0});
				access(cyc_mem_rd, 2'd0);
			end
		end
		finish_test();
	endtask

	task automatic test_rom_protect();
		start_test("rom_protect");
		do_reset(model_128);
		access(cyc_mem_wr, 2'd0);
		access(cyc_mem_rd, 2'd0);
		do_reset(model_plus3);
		access(cyc_mem_wr, 2'd0);
		issue(cyc_io_wr, 16'h1FFD, 8'h07);
		access(cyc_mem_wr, 2'd0);
		access(cyc_mem_wr, 2'd0);
		finish_test();
	endtask

	task automatic test_backpressure();
		logic [2:0] pick;
		start_test("backpressure");
		do_reset(model_plus3);
		stall_en <= 1'b1;
		for (int i = 0; i < BP_CYCLES; i++) begin
			pick = 3'(rnd(3));
			case (pick)
				// Lock bit kept clear so paging keeps moving
				3'd0:    issue(cyc_io_wr, 16'h7FFD, 8'(rnd(8)) & 8'hDF);
				3'd1:    issue(cyc_io_wr, 16'h1FFD, 8'(rnd(8)));
				3'd2:    idle();
				default: access(rnd(1) != 0 ? cyc_mem_wr : cyc_mem_rd, 2'(rnd(2)));
			endcase
		end
		drain();
		stall_en <= 1'b0;
		finish_test();
	endtask

	task automatic test_ula_port();
		start_test("ula_port");
		do_reset(model_48);
		check_ula();
		for (int i = 0; i < ULA_WRITES; i++) begin
			issue(cyc_io_wr, {15'(rnd(15)), 1'b0}, 8'(rnd(8)));
			access(cyc_mem_rd, 2'(rnd(2)));
			drain();
			check_ula();
		end
		issue(cyc_io_wr, 16'h00FE, 8'h1F);
		drain();
		check_ula();
		do_reset(model_48);
		check_ula();
		finish_test();
	endtask

	//==========================================================
	// Main sequence and watchdog
	//==========================================================

	initial begin
		reset     <= 1'b1;
		model     <= model_128;
		bus_valid <= 1'b0;
		bus_kind  <= cyc_mem_rd;
		bus_addr  <= '0;
		bus_data  <= '0;
		test_paging_128k();
		test_lock_and_model();
		test_plus3_special();
		test_rom_protect();
		test_backpressure();
		test_ula_port();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
			total_fails());
		if (tests_failed == 0 && total_fails() == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog timeout in test %s after %0d cycles", test_name,
			WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

/* tb_zx_pager_properties.sv */
//==========================================================
// Bound checker for the pager RAM output
// Request order, address, flags and hold under stall
//==========================================================

`timescale 1ns/1ps

module tb_zx_pager_properties
	import zx_pager_pkg::*;
(
	input logic                  clk_sys,
	input logic                  reset,
	input logic                  ram_valid,
	input logic                  ram_ready,
	input logic [RAM_ADDR_W-1:0] ram_addr,
	input logic                  ram_we,
	input logic                  ram_rd,
	input logic [7:0]            ram_din
);

	int assert_fails = 0;

	logic [RAM_ADDR_W+9:0] req;
	logic                  taken;

	// Same packing as the reference queue entries
	assign req   = {ram_we, ram_rd, ram_din, ram_addr};
	assign taken = ram_valid & ram_ready;

	// Every request that leaves the pager has to be expected
	a_req_expected: assert property (@(posedge clk_sys) disable iff (reset)
		taken |-> tb_zx_pager.exp_avail)
	else begin
		$error("Unexpected RAM request in test %s at address %h",
			tb_zx_pager.test_name, ram_addr);
		assert_fails++;
	end

	// Compared with the queue head so order and content are checked together
	a_req_match: assert property (@(posedge clk_sys) disable iff (reset)
		(taken && tb_zx_pager.exp_avail) |-> (req == tb_zx_pager.exp_head))
	else begin
		$error("MISMATCH %s expected %h actual %h",
			tb_zx_pager.test_name, tb_zx_pager.exp_head, req);
		assert_fails++;
	end

	a_hold_stalled: assert property (@(posedge clk_sys) disable iff (reset)
		(ram_valid && !ram_ready) |=> (ram_valid && $stable(req)))
	else begin
		$error("RAM request changed or withdrew while stalled in test %s",
			tb_zx_pager.test_name);
		assert_fails++;
	end

endmodule

/* zx_pager.sv */
//==========================================================
// Memory paging unit top level
// Chains bus decode, paging registers and address map
//==========================================================

`timescale 1ns/1ps

module zx_pager
	import zx_pager_pkg::*;
#(
	parameter logic [RAM_ADDR_W-1:0] RAM_BASE = '0
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  machine_model_t        model,

	// CPU bus
	input  logic                  bus_valid,
	input  cycle_kind_t           bus_kind,
	input  logic [CPU_ADDR_W-1:0] bus_addr,
	input  logic [7:0]            bus_data,
	output logic                  bus_ready,

	// External RAM
	output logic                  ram_valid,
	output logic [RAM_ADDR_W-1:0] ram_addr,
	output logic                  ram_we,
	output logic                  ram_rd,
	output logic [7:0]            ram_din,
	input  logic                  ram_ready,

	// ULA port state
	output logic [2:0]            border,
	output logic                  ear,
	output logic                  mic
);

	// Stage 1 to stage 2
	logic                  s1_valid;
	logic                  s1_ready;
	cycle_kind_t           s1_kind;
	logic [CPU_ADDR_W-1:0] s1_addr;
	logic [7:0]            s1_data;
	logic                  s1_sel_7ffd;
	logic                  s1_sel_1ffd;
	logic                  s1_sel_fe;

	// Stage 2 to stage 3
	logic                  s2_valid;
	logic                  s2_ready;
	cycle_kind_t           s2_kind;
	logic [CPU_ADDR_W-1:0] s2_addr;
	logic [7:0]            s2_data;
	paging_byte_t          s2_page7;
	paging_byte_t          s2_page3;
	machine_model_t        s2_model;

	bus_decode u_bus_decode (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bus_valid   (bus_valid),
		.bus_kind    (bus_kind),
		.bus_addr    (bus_addr),
		.bus_data    (bus_data),
		.bus_ready   (bus_ready),
		.s1_ready    (s1_ready),
		.s1_valid    (s1_valid),
		.s1_kind     (s1_kind),
		.s1_addr     (s1_addr),
		.s1_data     (s1_data),
		.s1_sel_7ffd (s1_sel_7ffd),
		.s1_sel_1ffd (s1_sel_1ffd),
		.s1_sel_fe   (s1_sel_fe)
	);

	paging_regs u_paging_regs (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.model       (model),
		.s1_valid    (s1_valid),
		.s1_kind     (s1_kind),
		.s1_addr     (s1_addr),
		.s1_data     (s1_data),
		.s1_sel_7ffd (s1_sel_7ffd),
		.s1_sel_1ffd (s1_sel_1ffd),
		.s1_sel_fe   (s1_sel_fe),
		.s1_ready    (s1_ready),
		.s2_ready    (s2_ready),
		.s2_valid    (s2_valid),
		.s2_kind     (s2_kind),
		.s2_addr     (s2_addr),
		.s2_data     (s2_data),
		.s2_page7    (s2_page7),
		.s2_page3    (s2_page3),
		.s2_model    (s2_model),
		.border      (border),
		.ear         (ear),
		.mic         (mic)
	);

	address_map #(
		.RAM_BASE (RAM_BASE)
	) u_address_map (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.s2_valid  (s2_valid),
		.s2_kind   (s2_kind),
		.s2_addr   (s2_addr),
		.s2_data   (s2_data),
		.s2_page7  (s2_page7),
		.s2_page3  (s2_page3),
		.s2_model  (s2_model),
		.s2_ready  (s2_ready),
		.ram_ready (ram_ready),
		.ram_valid (ram_valid),
		.ram_addr  (ram_addr),
		.ram_we    (ram_we),
		.ram_rd    (ram_rd),
		.ram_din   (ram_din)
	);

endmodule

/* address_map.sv */
//==========================================================
// Stage 3 of the pager pipeline
// RAM address, ROM write protection and the RAM request
//==========================================================

`timescale 1ns/1ps

module address_map
	import zx_pager_pkg::*;
#(
	parameter logic [RAM_ADDR_W-1:0] RAM_BASE = '0
) (
	input  logic                  clk_sys,
	input  logic                  reset,

	// From stage 2
	input  logic                  s2_valid,
	input  cycle_kind_t           s2_kind,
	input  logic [CPU_ADDR_W-1:0] s2_addr,
	input  logic [7:0]            s2_data,
	input  paging_byte_t          s2_page7,
	input  paging_byte_t          s2_page3,
	input  machine_model_t        s2_model,
	output logic                  s2_ready,

	// RAM request
	input  logic                  ram_ready,
	output logic                  ram_valid,
	output logic [RAM_ADDR_W-1:0] ram_addr,
	output logic                  ram_we,
	output logic                  ram_rd,
	output logic [7:0]            ram_din
);

	logic [1:0]            slot;
	logic                  special;
	logic [3:0]            rom_page;
	logic [2:0]            bank;
	logic [7:0]            region;
	logic [RAM_ADDR_W-1:0] addr_next;
	logic                  is_rd;
	logic                  is_wr;
	logic                  wr_ok;

	assign slot    = s2_addr[15:14];
	assign special = s2_page3.p1ffd.special;
	assign is_rd   = (s2_kind == cyc_mem_rd);
	assign is_wr   = (s2_kind == cyc_mem_wr);

	// Slot 0 is ROM unless an all-RAM mode is on
	assign wr_ok = special | (slot != 2'd0);

	//==========================================================
	// Region select
	//==========================================================

	always_comb begin
		case (s2_model)
			model_plus3:
				rom_page = {2'b10, s2_page3.p1ffd.special_cfg[1], s2_page7.p7ffd.rom_lo};
			model_128:
				rom_page = {3'b011, s2_page7.p7ffd.rom_lo};
			default:
				rom_page = 4'b0111;
		endcase
	end

	always_comb begin
		if (special) begin
			// All-RAM bank tables of the +3
			case (s2_page3.p1ffd.special_cfg)
				2'd0: bank = {1'b0, slot};
				2'd1: bank = {1'b1, slot};
				2'd2: bank = (slot == 2'd3) ? 3'd3 : {1'b1, slot};
				default: begin
					case (slot)
						2'd0:    bank = 3'd4;
						2'd1:    bank = 3'd7;
						2'd2:    bank = 3'd6;
						default: bank = 3'd3;
					endcase
				end
			endcase
		end else begin
			case (slot)
				2'd1:    bank = 3'd5;
				2'd2:    bank = 3'd2;
				default: bank = s2_page7.p7ffd.bank;
			endcase
		end
	end

	assign region    = (~special && slot == 2'd0) ? {ROM_REGION, rom_page} : {5'd0, bank};
	assign addr_next = RAM_BASE + {3'd0, region, s2_addr[13:0]};

	//==========================================================
	// Output register
	//==========================================================

	assign s2_ready = ~ram_valid | ram_ready;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_valid <= 1'b0;
			ram_addr  <= '0;
			ram_we    <= 1'b0;
			ram_rd    <= 1'b0;
			ram_din   <= '0;
		end else if (s2_ready) begin
			// A blocked ROM write leaves without a request
			ram_valid <= s2_valid & ~(is_wr & ~wr_ok);
			if (s2_valid) begin
				ram_addr <= addr_next;
				ram_we   <= is_wr & wr_ok;
				ram_rd   <= is_rd;
				ram_din  <= s2_data;
			end
		end
	end

endmodule

/* paging_regs.sv */
//==========================================================
// Stage 2 of the pager pipeline
// 7FFD, 1FFD and ULA port registers, consumes I/O writes
// and tags memory cycles with the current paging state
//==========================================================

`timescale 1ns/1ps

module paging_regs
	import zx_pager_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  machine_model_t        model,

	// From stage 1
	input  logic                  s1_valid,
	input  cycle_kind_t           s1_kind,
	input  logic [CPU_ADDR_W-1:0] s1_addr,
	input  logic [7:0]            s1_data,
	input  logic                  s1_sel_7ffd,
	input  logic                  s1_sel_1ffd,
	input  logic                  s1_sel_fe,
	output logic                  s1_ready,

	// Towards stage 3
	input  logic                  s2_ready,
	output logic                  s2_valid,
	output cycle_kind_t           s2_kind,
	output logic [CPU_ADDR_W-1:0] s2_addr,
	output logic [7:0]            s2_data,
	output paging_byte_t          s2_page7,
	output paging_byte_t          s2_page3,
	output machine_model_t        s2_model,

	// ULA port state
	output logic [2:0]            border,
	output logic                  ear,
	output logic                  mic
);

	logic           item_valid;
	logic           sel_7ffd_q;
	logic           sel_1ffd_q;
	logic           sel_fe_q;
	logic           is_io;
	logic           consume_io;
	logic           wr_7ffd;
	logic           wr_1ffd;
	logic           wr_fe;
	paging_byte_t   page7_q;
	paging_byte_t   page3_q;
	machine_model_t model_q;

	//==========================================================
	// Handshake
	//==========================================================

	assign is_io      = (s2_kind == cyc_io_wr);
	assign consume_io = item_valid & is_io;

	// I/O writes never go downstream, they drain here
	assign s2_valid = item_valid & ~is_io;
	assign s1_ready = ~item_valid | is_io | s2_ready;

	//==========================================================
	// Port write qualification
	//==========================================================

	// 7FFD needs A14 high on +3, where A14 low is the 1FFD space
	assign wr_7ffd = consume_io & sel_7ffd_q & (model_q != model_48) &
		~page7_q.p7ffd.lock & ((model_q != model_plus3) | s2_addr[14]);
	assign wr_1ffd = consume_io & sel_1ffd_q & (model_q == model_plus3) &
		~page7_q.p7ffd.lock;
	assign wr_fe   = consume_io & sel_fe_q;

	// Paging state only moves when an I/O item drains, so it is
	// stable for any memory item held here
	assign s2_page7 = page7_q;
	assign s2_page3 = page3_q;
	assign s2_model = model_q;

	//==========================================================
	// Stage register
	//==========================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			item_valid <= 1'b0;
			s2_kind    <= cyc_mem_rd;
			s2_addr    <= '0;
			s2_data    <= '0;
			sel_7ffd_q <= 1'b0;
			sel_1ffd_q <= 1'b0;
			sel_fe_q   <= 1'b0;
		end else if (s1_ready) begin
			item_valid <= s1_valid;
			if (s1_valid) begin
				s2_kind    <= s1_kind;
				s2_addr    <= s1_addr;
				s2_data    <= s1_data;
				sel_7ffd_q <= s1_sel_7ffd;
				sel_1ffd_q <= s1_sel_1ffd;
				sel_fe_q   <= s1_sel_fe;
			end
		end
	end

	//==========================================================
	// Paging and ULA registers
	//==========================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			// Model is taken while reset is held
			model_q <= model;
			page7_q <= '0;
			page3_q <= '0;
			border  <= '0;
			ear     <= 1'b0;
			mic     <= 1'b0;
		end else begin
			if (wr_7ffd)
				page7_q <= paging_byte_t'(s2_data);
			if (wr_1ffd)
				page3_q <= paging_byte_t'(s2_data);
			// ULA port, bit 4 ear and bit 3 mic
			if (wr_fe) begin
				border <= s2_data[2:0];
				ear    <= s2_data[4];
				mic    <= s2_data[3];
			end
		end
	end

endmodule

/* bus_decode.sv */
//==========================================================
// Stage 1 of the pager pipeline
// Registers bus cycles and decodes the I/O port selects
//==========================================================

`timescale 1ns/1ps

module bus_decode
	import zx_pager_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,

	// CPU bus side
	input  logic                  bus_valid,
	input  cycle_kind_t           bus_kind,
	input  logic [CPU_ADDR_W-1:0] bus_addr,
	input  logic [7:0]            bus_data,
	output logic                  bus_ready,

	// Towards stage 2
	input  logic                  s1_ready,
	output logic                  s1_valid,
	output cycle_kind_t           s1_kind,
	output logic [CPU_ADDR_W-1:0] s1_addr,
	output logic [7:0]            s1_data,
	output logic                  s1_sel_7ffd,
	output logic                  s1_sel_1ffd,
	output logic                  s1_sel_fe
);

	logic io_wr;
	logic dec_7ffd;
	logic dec_1ffd;
	logic dec_fe;

	//==========================================================
	// Port decode, I/O writes only
	//==========================================================

	assign io_wr = (bus_kind == cyc_io_wr);

	// Partial decode as on the real machines
	assign dec_7ffd = io_wr & ~bus_addr[15] & ~bus_addr[1];
	assign dec_1ffd = io_wr & ~bus_addr[1] & bus_addr[12] &
		~bus_addr[13] & ~bus_addr[14] & ~bus_addr[15];
	assign dec_fe   = io_wr & ~bus_addr[0];

	// Room when empty or the held item leaves this cycle
	assign bus_ready = ~s1_valid | s1_ready;

	//==========================================================
	// Stage register
	//==========================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			s1_valid    <= 1'b0;
			s1_kind     <= cyc_mem_rd;
			s1_addr     <= '0;
			s1_data     <= '0;
			s1_sel_7ffd <= 1'b0;
			s1_sel_1ffd <= 1'b0;
			s1_sel_fe   <= 1'b0;
		end else if (bus_ready) begin
			s1_valid <= bus_valid;
			if (bus_valid) begin
				s1_kind     <= bus_kind;
				s1_addr     <= bus_addr;
				s1_data     <= bus_data;
				s1_sel_7ffd <= dec_7ffd;
				s1_sel_1ffd <= dec_1ffd;
				s1_sel_fe   <= dec_fe;
			end
		end
	end

endmodule

/* zx_pager_pkg.sv */
//==========================================================
// Shared types and constants of the paging unit
// Machine model, bus cycle kinds, paging byte views and
// address constants
//==========================================================

package zx_pager_pkg;

	//==========================================================
	// Widths and address constants
	//==========================================================

	localparam int RAM_ADDR_W = 25;
	localparam int CPU_ADDR_W = 16;

	// Prefix above the 4-bit ROM page, lands at bit 18 of RAM address
	localparam logic [3:0] ROM_REGION = 4'b1010;

	//==========================================================
	// Enumerations
	//==========================================================

	typedef enum logic [1:0] {
		model_48    = 2'd0,
		model_128   = 2'd1,
		model_plus3 = 2'd2
	} machine_model_t;

	typedef enum logic [1:0] {
		cyc_mem_rd = 2'd0,
		cyc_mem_wr = 2'd1,
		cyc_io_wr  = 2'd2
	} cycle_kind_t;

	//==========================================================
	// Paging byte, one data byte seen as 7FFD or 1FFD
	//==========================================================

	// 128K paging port
	typedef struct packed {
		logic [1:0] unused;
		logic       lock;
		logic       rom_lo;
		logic       scr;
		logic [2:0] bank;
	} page_7ffd_t;

	// +3 paging port, motor is kept but drives nothing here
	typedef struct packed {
		logic [3:0] unused;
		logic       motor;
		logic [1:0] special_cfg;
		logic       special;
	} page_1ffd_t;

	typedef union packed {
		page_7ffd_t p7ffd;
		page_1ffd_t p1ffd;
	} paging_byte_t;

endpackage
